// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // datapath and bus widths
  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int AXI_ADDR_W = 32;
  localparam int REG_NUM    = 32;
  localparam int REG_AW     = 5;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // dummy no-op and the full ebreak word
  localparam logic [ILEN-1:0] NOP_WORD    = 32'h0000_0000;
  localparam logic [ILEN-1:0] EBREAK_WORD = 32'h0010_0073;

  // func3 of the supported I and S encodings
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_SD   = 3'b011;

  // axi prot: instruction fetch vs plain data access
  localparam logic [2:0] PROT_INST = 3'b100;
  localparam logic [2:0] PROT_DATA = 3'b000;
  // sd writes all eight bytes
  localparam logic [7:0] STRB_FULL = 8'hff;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } rv_opcode_e;

  // what the decoder asks of execute and the sequencer
  typedef enum logic [2:0] {
    EXU_NOP,
    EXU_ADD,
    EXU_JUMP,
    EXU_STORE,
    EXU_HALT,
    EXU_TRAP
  } exu_op_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_STORE,
    ST_HALT
  } core_state_e;

  typedef struct packed {
    exu_op_e           op;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   op1_jump;
    logic [XLEN-1:0]   op2_jump;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [REG_AW-1:0] rd_addr;
    logic              rd_we;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] store_addr;
    logic [XLEN-1:0] store_data;
  } exec_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } axil_ar_t;

  typedef struct packed {
    logic [ILEN-1:0] data;
    logic [1:0]      resp;
  } axil_r_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [2:0]            prot;
  } axil_aw_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [7:0]      strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

endpackage

`default_nettype wire

// File: rv_core_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_ifu import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  // instruction read port
  output logic            ar_valid,
  input  logic            ar_ready,
  output axil_ar_t        ar,
  input  logic            r_valid,
  output logic            r_ready,
  input  axil_r_t         r,
  // decode and execute results
  input  decode_t         dec,
  input  exec_t           exe,
  output logic [XLEN-1:0] pc,
  output logic [ILEN-1:0] inst,
  output logic            wb_en,
  // store handoff
  output logic            store_start,
  input  logic            store_done,
  output logic            halted,
  output logic            trap
);

  core_state_e state;
  // address phase already accepted, waiting for r
  logic        ar_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_FETCH;
      pc       <= RESET_PC;
      ar_valid <= 1'b0;
      ar_done  <= 1'b0;
      trap     <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          // one ar per instruction, dropped once accepted
          if (ar_valid && ar_ready) begin
            ar_valid <= 1'b0;
            ar_done  <= 1'b1;
          end else if (!ar_valid && !ar_done) begin
            ar_valid <= 1'b1;
          end
          if (r_valid && r_ready) begin
            ar_done <= 1'b0;
            state   <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          pc <= exe.next_pc;
          case (dec.op)
            EXU_STORE: state <= ST_STORE;
            EXU_HALT:  state <= ST_HALT;
            EXU_TRAP: begin
              state <= ST_HALT;
              trap  <= 1'b1;
            end
            default:   state <= ST_FETCH;
          endcase
        end
        // pc already moved on, just wait for the b response
        ST_STORE: if (store_done) state <= ST_FETCH;
        // absorbing until reset
        default:  state <= ST_HALT;
      endcase
    end
  end

  // fetched word, only meaningful in exec
  always_ff @(posedge clk) begin
    if (state == ST_FETCH && r_valid) inst <= r.data;
  end

  assign ar.addr     = pc[AXI_ADDR_W-1:0];
  assign ar.prot     = PROT_INST;
  assign r_ready     = (state == ST_FETCH);
  assign wb_en       = (state == ST_EXEC) && dec.rd_we;
  assign store_start = (state == ST_EXEC) && (dec.op == EXU_STORE);
  assign halted      = (state == ST_HALT);

endmodule

`default_nettype wire

// File: rv_core_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_idu import rv_core_pkg::*; (
  input  logic [XLEN-1:0] pc,
  input  logic [ILEN-1:0] inst,
  input  logic [XLEN-1:0] rs1_data,
  output decode_t         dec
);

  // instruction fields
  logic [6:0]        opcode;
  logic [2:0]        func3;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;

  // sign-extended immediates
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign func3  = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  // S type splits the immediate around rd
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // J type bit scramble, bit 0 always zero
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // anything not matched below traps
    dec    = '0;
    dec.op = EXU_TRAP;
    if (inst == NOP_WORD) begin
      dec.op = EXU_NOP;
    end else if (inst == EBREAK_WORD) begin
      dec.op = EXU_HALT;
    end else begin
      case (opcode)
        OPC_OP_IMM: begin
          if (func3 == F3_ADDI) begin
            dec.op       = EXU_ADD;
            dec.rs1_addr = rs1;
            dec.op1      = rs1_data;
            dec.op2      = imm_i;
            dec.rd_addr  = rd;
            dec.rd_we    = 1'b1;
          end
        end
        OPC_LUI: begin
          // op1 stays zero
          dec.op      = EXU_ADD;
          dec.op2     = imm_u;
          dec.rd_addr = rd;
          dec.rd_we   = 1'b1;
        end
        OPC_AUIPC: begin
          dec.op      = EXU_ADD;
          dec.op1     = pc;
          dec.op2     = imm_u;
          dec.rd_addr = rd;
          dec.rd_we   = 1'b1;
        end
        OPC_JAL: begin
          // link value through op1/op2, target through the jump pair
          dec.op       = EXU_JUMP;
          dec.op1      = pc;
          dec.op2      = 64'd4;
          dec.op1_jump = pc;
          dec.op2_jump = imm_j;
          dec.rd_addr  = rd;
          dec.rd_we    = 1'b1;
        end
        OPC_JALR: begin
          if (func3 == F3_JALR) begin
            dec.op       = EXU_JUMP;
            dec.rs1_addr = rs1;
            dec.op1      = pc;
            dec.op2      = 64'd4;
            dec.op1_jump = rs1_data;
            dec.op2_jump = imm_i;
            dec.rd_addr  = rd;
            dec.rd_we    = 1'b1;
          end
        end
        OPC_STORE: begin
          // address from the adder, data straight from rs2
          if (func3 == F3_SD) begin
            dec.op       = EXU_STORE;
            dec.rs1_addr = rs1;
            dec.rs2_addr = rs2;
            dec.op1      = rs1_data;
            dec.op2      = imm_s;
          end
        end
        default: begin
          dec.op = EXU_TRAP;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rv_core_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_regfile import rv_core_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  // read ports
  input  logic [REG_AW-1:0] rs1_addr,
  input  logic [REG_AW-1:0] rs2_addr,
  output logic [XLEN-1:0]   rs1_data,
  output logic [XLEN-1:0]   rs2_data,
  // write port
  input  logic              we,
  input  logic [REG_AW-1:0] rd_addr,
  input  logic [XLEN-1:0]   rd_data
);

  logic [XLEN-1:0] regs [REG_NUM];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      // x0 never written so it reads back zero
      regs[rd_addr] <= rd_data;
    end
  end

  // asynchronous reads
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: rv_core_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_exu import rv_core_pkg::*; (
  input  logic [XLEN-1:0] pc,
  input  decode_t         dec,
  input  logic [XLEN-1:0] rs2_data,
  output exec_t           exe
);

  // main adder, shared by write-back and store address
  logic [XLEN-1:0] sum;
  // separate jump target adder
  logic [XLEN-1:0] jump_sum;
  logic [XLEN-1:0] seq_pc;

  assign sum      = dec.op1 + dec.op2;
  assign jump_sum = dec.op1_jump + dec.op2_jump;
  assign seq_pc   = pc + 64'd4;

  always_comb begin
    exe.wb_data    = sum;
    exe.store_addr = sum;
    exe.store_data = rs2_data;
    // jalr target has bit 0 cleared, harmless for jal
    if (dec.op == EXU_JUMP) begin
      exe.next_pc = {jump_sum[XLEN-1:1], 1'b0};
    end else begin
      exe.next_pc = seq_pc;
    end
  end

endmodule

`default_nettype wire

// File: rv_core_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_lsu import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  // store request from the sequencer
  input  logic            start,
  input  logic [XLEN-1:0] addr,
  input  logic [XLEN-1:0] data,
  output logic            done,
  // axi4-lite write master
  output logic            aw_valid,
  input  logic            aw_ready,
  output axil_aw_t        aw,
  output logic            w_valid,
  input  logic            w_ready,
  output axil_w_t         w,
  input  logic            b_valid,
  output logic            b_ready,
  input  axil_b_t         b
);

  logic                  busy;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic [XLEN-1:0]       data_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else if (start) begin
      busy     <= 1'b1;
      aw_valid <= 1'b1;
      w_valid  <= 1'b1;
    end else begin
      // aw and w retire on their own
      if (aw_valid && aw_ready) aw_valid <= 1'b0;
      if (w_valid && w_ready) w_valid <= 1'b0;
      if (done) busy <= 1'b0;
    end
  end

  // payload held until both channels are done
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= addr[AXI_ADDR_W-1:0];
      data_q <= data;
    end
  end

  assign aw.addr = addr_q;
  assign aw.prot = PROT_DATA;
  assign w.data  = data_q;
  assign w.strb  = STRB_FULL;

  // response only after both aw and w went through
  assign b_ready = busy && !aw_valid && !w_valid;
  // b.resp is accepted but not acted on
  assign done    = b_valid && b_ready;

endmodule

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  // instruction read port
  output logic     ar_valid,
  input  logic     ar_ready,
  output axil_ar_t ar,
  input  logic     r_valid,
  output logic     r_ready,
  input  axil_r_t  r,
  // store write port
  output logic     aw_valid,
  input  logic     aw_ready,
  output axil_aw_t aw,
  output logic     w_valid,
  input  logic     w_ready,
  output axil_w_t  w,
  input  logic     b_valid,
  output logic     b_ready,
  input  axil_b_t  b,
  // status
  output logic     halted,
  output logic     trap
);

  logic [XLEN-1:0] pc;
  logic [ILEN-1:0] inst;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  decode_t         dec;
  exec_t           exe;
  logic            wb_en;
  logic            store_start;
  logic            store_done;

  // fetch and sequencing
  rv_core_ifu u_ifu (
    .clk         (clk),
    .arst_n      (arst_n),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar          (ar),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r           (r),
    .dec         (dec),
    .exe         (exe),
    .pc          (pc),
    .inst        (inst),
    .wb_en       (wb_en),
    .store_start (store_start),
    .store_done  (store_done),
    .halted      (halted),
    .trap        (trap)
  );

  rv_core_idu u_idu (
    .pc       (pc),
    .inst     (inst),
    .rs1_data (rs1_data),
    .dec      (dec)
  );

  rv_core_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (dec.rs1_addr),
    .rs2_addr (dec.rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_en),
    .rd_addr  (dec.rd_addr),
    .rd_data  (exe.wb_data)
  );

  rv_core_exu u_exu (
    .pc       (pc),
    .dec      (dec),
    .rs2_data (rs2_data),
    .exe      (exe)
  );

  // sd goes out here
  rv_core_lsu u_lsu (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (store_start),
    .addr     (exe.store_addr),
    .data     (exe.store_data),
    .done     (store_done),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b)
  );

endmodule

`default_nettype wire

// File: rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_core_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input logic     ar_valid,
  input logic     ar_ready,
  input axil_ar_t ar,
  input logic     aw_valid,
  input logic     aw_ready,
  input axil_aw_t aw,
  input logic     w_valid,
  input logic     w_ready,
  input axil_w_t  w,
  input logic     halted
);

  // master valids hold with a stable payload until accepted
  a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("ar_valid dropped or ar changed before ar_ready");

  a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw_valid dropped or aw changed before aw_ready");

  a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w_valid dropped or w changed before w_ready");

  // halt is absorbing, no more fetches
  a_halt_no_fetch: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> !ar_valid)
    else $error("ar_valid raised while halted");

  // first edge after reset release sees a quiet bus
  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> !ar_valid && !aw_valid && !w_valid)
    else $error("valid high in the first cycle after reset");

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_PROG     = 6;
  // new instruction addresses per program before ebreak
  localparam int BUDGET     = 48;
  // one program gets an undefined word at this position
  localparam int TRAP_PROG  = 2;
  localparam int TRAP_AT    = 20;
  // slli x1, x1, 1 is legal rv64 but not decoded here
  localparam logic [ILEN-1:0] BAD_WORD = 32'h0010_9093;
  localparam longint WATCHDOG_NS = longint'(N_PROG) * BUDGET * 20 * CLK_PERIOD;

  logic     clk;
  logic     arst_n;
  logic     ar_valid;
  logic     ar_ready;
  axil_ar_t ar;
  logic     r_valid;
  logic     r_ready;
  axil_r_t  r;
  logic     aw_valid;
  logic     aw_ready;
  axil_aw_t aw;
  logic     w_valid;
  logic     w_ready;
  axil_w_t  w;
  logic     b_valid;
  logic     b_ready;
  axil_b_t  b;
  logic     halted;
  logic     trap;

  logic [31:0] seed;
  // lazy instruction memory filled on first fetch
  logic [ILEN-1:0] imem [logic [31:0]];
  int gen_count;

  // reference model state
  logic [XLEN-1:0] m_pc;
  logic [XLEN-1:0] m_x [32];
  // register last written by lui or auipc
  logic            m_ui [32];
  logic            m_halt;
  logic            m_trap;
  logic            m_st_pend;
  logic [XLEN-1:0] m_st_addr;
  logic [XLEN-1:0] m_st_data;

  // slave side bookkeeping
  int   ar_wait;
  int   r_wait;
  int   aw_wait;
  int   w_wait;
  int   b_wait;
  logic r_pend;
  logic b_pend;
  logic aw_seen;
  logic w_seen;

  rv_core_top uut (
    .clk      (clk),
    .arst_n   (arst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .halted   (halted),
    .trap     (trap)
  );

  bind rv_core_top rv_core_properties u_props (
    .clk      (clk),
    .arst_n   (arst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // 0 to 3 idle cycles
  function automatic int stall();
    return int'((next_rand() >> 13) % 32'd4);
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, expected %h, got %h", $time, what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // raise a handshake line once the stall count runs out
  task automatic apply_stall(input logic active, inout int wait_cnt, output logic level);
    level = 1'b0;
    if (active) begin
      if (wait_cnt == 0) level = 1'b1;
      else wait_cnt--;
    end
  endtask

  task automatic idle_inputs();
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r        = '0;
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    b_valid  = 1'b0;
    b        = '0;
  endtask

  function automatic logic [ILEN-1:0] random_inst();
    logic [ILEN-1:0] word;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      idx;
    logic [11:0]     imm12;
    logic [19:0]     imm20;
    logic [20:0]     joff;
    logic [XLEN-1:0] diff;
    logic            found;
    int              kind;
    int              start;
    rd    = 5'(next_rand() >> 11);
    rs1   = 5'(next_rand() >> 11);
    rs2   = 5'(next_rand() >> 11);
    imm12 = 12'(next_rand() >> 8);
    imm20 = 20'(next_rand() >> 4);
    kind  = int'((next_rand() >> 16) % 32'd8);
    // addi is also the fallback for jalr
    word  = {imm12, rs1, 3'b000, rd, 7'b0010011};
    case (kind)
      1: word = {imm20, rd, 7'b0110111};
      2: begin
        // zero offset gives a usable jalr base
        if (((next_rand() >> 20) & 32'd1) == 32'd0) imm20 = '0;
        word = {imm20, rd, 7'b0010111};
      end
      3: begin
        // forward only so there are no loops
        joff = 21'(4 * (1 + int'((next_rand() >> 16) % 32'd8)));
        word = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      end
      4: begin
        found = 1'b0;
        start = int'((next_rand() >> 11) % 32'd32);
        for (int k = 0; k < 32; k++) begin
          idx = 5'(start + k);
          if (!found && idx != 5'd0 && m_ui[idx]) begin
            // forward target with an odd offset now and then
            diff = m_pc + 64'(4 * (1 + int'((next_rand() >> 16) % 32'd8))) - m_x[idx];
            diff = diff + 64'((next_rand() >> 9) & 32'd1);
            if ($signed(diff) >= -64'sd2048 && $signed(diff) <= 64'sd2047) begin
              found = 1'b1;
              word  = {diff[11:0], idx, 3'b000, rd, 7'b1100111};
            end
          end
        end
      end
      5, 6: word = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], 7'b0100011};
      7: word = NOP_WORD;
      default: ;
    endcase
    return word;
  endfunction

  // same word for every later fetch of an address
  function automatic logic [ILEN-1:0] fetch_word(input logic [31:0] addr, input int prog);
    logic [ILEN-1:0] word;
    if (imem.exists(addr)) return imem[addr];
    if (gen_count >= BUDGET) word = EBREAK_WORD;
    else if (prog == TRAP_PROG && gen_count == TRAP_AT) word = BAD_WORD;
    else word = random_inst();
    gen_count++;
    imem[addr] = word;
    return word;
  endfunction

  task automatic write_reg(input logic [4:0] rd, input logic [XLEN-1:0] val,
                           input logic from_ui);
    if (rd != 5'd0) begin
      m_x[rd]  = val;
      m_ui[rd] = from_ui;
    end
  endtask

  // iss step for one fetched word
  task automatic model_step(input logic [ILEN-1:0] word);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] target;
    opc   = word[6:0];
    rd    = word[11:7];
    f3    = word[14:12];
    rs1   = word[19:15];
    rs2   = word[24:20];
    imm_i = 64'($signed(word[31:20]));
    imm_s = 64'($signed({word[31:25], word[11:7]}));
    imm_u = 64'($signed({word[31:12], 12'h000}));
    imm_j = 64'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
    link  = m_pc + 64'd4;
    if (word == NOP_WORD) begin
      m_pc = link;
    end else if (word == EBREAK_WORD) begin
      m_halt = 1'b1;
    end else if (opc == 7'b0010011 && f3 == 3'b000) begin
      write_reg(rd, m_x[rs1] + imm_i, 1'b0);
      m_pc = link;
    end else if (opc == 7'b0110111) begin
      write_reg(rd, imm_u, 1'b1);
      m_pc = link;
    end else if (opc == 7'b0010111) begin
      write_reg(rd, m_pc + imm_u, 1'b1);
      m_pc = link;
    end else if (opc == 7'b1101111) begin
      write_reg(rd, link, 1'b0);
      m_pc = m_pc + imm_j;
    end else if (opc == 7'b1100111 && f3 == 3'b000) begin
      // target read before rd may overwrite rs1
      target = (m_x[rs1] + imm_i) & ~64'h1;
      write_reg(rd, link, 1'b0);
      m_pc = target;
    end else if (opc == 7'b0100011 && f3 == 3'b011) begin
      m_st_addr = m_x[rs1] + imm_s;
      m_st_data = m_x[rs2];
      m_st_pend = 1'b1;
      m_pc      = link;
    end else begin
      m_halt = 1'b1;
      m_trap = 1'b1;
    end
  endtask

  task automatic start_program();
    @(negedge clk);
    arst_n = 1'b0;
    idle_inputs();
    r_pend    = 1'b0;
    b_pend    = 1'b0;
    aw_seen   = 1'b0;
    w_seen    = 1'b0;
    ar_wait   = stall();
    aw_wait   = stall();
    w_wait    = stall();
    imem.delete();
    gen_count = 0;
    m_pc      = RESET_PC;
    m_halt    = 1'b0;
    m_trap    = 1'b0;
    m_st_pend = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_x[i]  = '0;
      m_ui[i] = 1'b0;
    end
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    check_equal(64'(halted), 64'd0, "halted right after reset");
  endtask

  // handshakes resolved in one slave cycle land on the next rising edge
  task automatic serve_cycle(input int prog);
    @(negedge clk);
    // r before ar so a response never comes in the cycle of its ar
    apply_stall(r_pend, r_wait, r_valid);
    if (r_valid && r_ready) begin
      r_pend = 1'b0;
      model_step(r.data);
    end
    apply_stall(ar_valid, ar_wait, ar_ready);
    if (ar_valid && ar_ready) begin
      check_equal(64'(m_halt), 64'd0, "fetch after halt");
      check_equal(64'(ar.addr), 64'(m_pc[31:0]), "fetch address");
      // instruction access sets prot bit 2
      check_equal(64'(ar.prot), 64'h4, "fetch prot");
      r.data  = fetch_word(ar.addr, prog);
      r.resp  = 2'b00;
      r_pend  = 1'b1;
      r_wait  = stall();
      ar_wait = stall();
    end
    // b only once both aw and w went through
    apply_stall(b_pend, b_wait, b_valid);
    if (b_valid && b_ready) b_pend = 1'b0;
    apply_stall(aw_valid, aw_wait, aw_ready);
    if (aw_valid && aw_ready) begin
      check_equal(64'(m_st_pend), 64'd1, "store address without sd");
      check_equal(64'(aw.addr), 64'(m_st_addr[31:0]), "store address");
      // plain unprivileged data access
      check_equal(64'(aw.prot), 64'h0, "store prot");
      aw_seen = 1'b1;
      aw_wait = stall();
    end
    apply_stall(w_valid, w_wait, w_ready);
    if (w_valid && w_ready) begin
      check_equal(64'(m_st_pend), 64'd1, "store data without sd");
      check_equal(w.data, m_st_data, "store data");
      check_equal(64'(w.strb), 64'hff, "store strobes");
      w_seen = 1'b1;
      w_wait = stall();
    end
    if (aw_seen && w_seen) begin
      aw_seen   = 1'b0;
      w_seen    = 1'b0;
      m_st_pend = 1'b0;
      b_pend    = 1'b1;
      b_wait    = stall();
    end
  endtask

  initial begin
    seed   = 32'hb6f6_665f;
    arst_n = 1'b0;
    idle_inputs();
    for (int p = 0; p < N_PROG; p++) begin
      start_program();
      while (!m_halt) serve_cycle(p);
      // long enough for a stray fetch to complete
      repeat (8) serve_cycle(p);
      check_equal(64'(halted), 64'd1, "halted at end of program");
      check_equal(64'(trap), 64'(m_trap), "trap flag at end of program");
    end
    $display("TB PASSED");
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: the core hung, the programs did not finish in time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: project.f
rv_core_pkg.sv
rv_core_ifu.sv
rv_core_idu.sv
rv_core_regfile.sv
rv_core_exu.sv
rv_core_lsu.sv
rv_core_top.sv
rv_core_properties.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build the rv_core testbench with verilator, run it, scan the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_rv_core \
  -f project.f --Mdir obj_dir -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0
